/* Makefile */
# Verilator build and run of the csr unit testbench

VERILATOR ?= verilator
TOP       ?= csr_unit_tb
FILELIST  ?= csr_unit.f
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIMARGS   ?= +verilator+error+limit+100

.PHONY: sim clean

# build, run, and fail unless the pass message shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	@out=$$(./$(BUILD)/V$(TOP) $(SIMARGS)); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf $(BUILD)

/* bench/csr_unit_assert.sv */
// protocol assertions on the csr unit pins that bind attaches to every csr_unit instance
`timescale 1ns/1ps

module csr_unit_assert (
  input logic        clk,
  input logic        rst,
  input logic        stall,
  input logic        trap_taken,
  input logic        trap_return,
  input logic [31:0] trap_addr
);

  int fail_count = 0;  // assertion failures seen so far

  // entry and return never share a cycle
  a_excl: assert property (@(posedge clk) disable iff (!rst) !(trap_taken && trap_return))
    else begin
      $error("trap_taken and trap_return high together");
      fail_count++;
    end

  // one-cycle take unless a stall freezes it
  a_single: assert property (@(posedge clk) disable iff (!rst)
                             trap_taken && !stall |=> !trap_taken)
    else begin
      $error("trap_taken high on two cycles in a row");
      fail_count++;
    end

  a_align: assert property (@(posedge clk) disable iff (!rst)
                            trap_taken |-> trap_addr[1:0] == 2'b00)
    else begin
      $error("trap_addr not word aligned");
      fail_count++;
    end

  // quiet outputs during reset
  a_reset: assert property (@(posedge clk) !rst |-> !trap_taken && !trap_return)
    else begin
      $error("trap output high during reset");
      fail_count++;
    end

endmodule

bind csr_unit csr_unit_assert u_assert (
  .clk(clk), .rst(rst), .stall(stall),
  .trap_taken(trap_taken), .trap_return(trap_return), .trap_addr(trap_addr)
);

/* bench/csr_unit_tb.sv */
// self-checking testbench that applies a table of csr instructions to csr_unit and checks each result
`timescale 1ns/1ps

module csr_unit_tb;

  localparam logic [11:0] A_MSTATUS  = 12'h300;
  localparam logic [11:0] A_MIE      = 12'h304;
  localparam logic [11:0] A_MTVEC    = 12'h305;
  localparam logic [11:0] A_MSCRATCH = 12'h340;
  localparam logic [11:0] A_MEPC     = 12'h341;
  localparam logic [11:0] A_MCAUSE   = 12'h342;
  localparam logic [11:0] A_MTVAL    = 12'h343;
  localparam logic [2:0]  OP_RW = 3'b001, OP_RS = 3'b010, OP_RC = 3'b011;
  localparam logic [2:0]  OP_RWI = 3'b101, OP_RSI = 3'b110, OP_RCI = 3'b111;
  localparam logic [31:0] MPP_M = 32'h0000_1800;  // mpp fixed at machine
  localparam int RESET_CYCLES = 4;

  typedef struct packed {
    logic valid, stall, flush;
    logic irq_sw, irq_tmr, irq_ext;
    logic illegal, ecall, ebreak, mret, is_load, is_store;
    logic [1:0]  mem_size;
    logic [31:0] mem_addr;
    logic [2:0]  op;
    logic [11:0] addr;
    logic [4:0]  rs1;
    logic [31:0] rs1_data, pc;
    logic chk_out, chk_taken, chk_ret, chk_taddr, chk_raddr;  // which fields to compare
    logic [31:0] exp_out;
    logic exp_taken, exp_ret;
    logic [31:0] exp_taddr, exp_raddr;
  } row_t;

  logic clk, rst, valid, stall, flush;
  logic irq_software, irq_timer, irq_external;
  logic illegal_instr, ecall, ebreak, mret, is_load, is_store;
  logic [1:0]  mem_size;
  logic [31:0] mem_addr, rs1_data, pc;
  logic [2:0]  csr_op;
  logic [11:0] csr_addr;
  logic [4:0]  rs1;
  logic [31:0] csr_out, trap_addr, return_addr;
  logic        trap_taken, trap_return;

  row_t        rows[$];
  logic [31:0] rng;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          cycle_limit = 1000000;  // replaced once the table is known

  csr_unit UUT (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // guard against a hung run
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("run timed out after %0d cycles", cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_word();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic row_t idle_row();
    row_t t;
    t = '0;
    t.valid = 1'b1;  // valid with no csr op and no trap source
    return t;
  endfunction

  // csr instruction whose old value is expected on csr_out
  function automatic row_t csr_row(input logic [2:0] op, input logic [11:0] addr,
                                   input logic [4:0] idx, input logic [31:0] data,
                                   input logic [31:0] old);
    row_t t;
    t = idle_row();
    t.op       = op;
    t.addr     = addr;
    t.rs1      = idx;
    t.rs1_data = data;
    t.chk_out  = 1'b1;
    t.exp_out  = old;
    return t;
  endfunction

  function automatic row_t read_row(input logic [11:0] addr, input logic [31:0] old);
    return csr_row(OP_RS, addr, 5'd0, 32'd0, old);  // set with zero leaves it alone
  endfunction

  function automatic row_t expect_trap(input row_t t, input logic taken,
                                       input logic [31:0] taddr);
    row_t r;
    r = t;
    r.chk_taken = 1'b1;
    r.exp_taken = taken;
    r.chk_ret   = 1'b1;
    r.exp_ret   = 1'b0;
    r.chk_taddr = taken;
    r.exp_taddr = taddr;
    return r;
  endfunction

  task automatic build_table();
    logic [2:0]  ops [6];
    logic [2:0]  op;
    logic [31:0] data, src, scratch, base, vbase, p1, p2, p3, maddr, w;
    logic [4:0]  idx;
    row_t        t;
    ops = '{OP_RW, OP_RS, OP_RC, OP_RWI, OP_RSI, OP_RCI};
    scratch = 32'd0;
    rows.push_back(read_row(A_MSTATUS, MPP_M));  // reset values
    rows.push_back(read_row(A_MTVEC, 32'd0));
    for (int k = 0; k < 12; k++) begin
      op   = ops[k % 6];
      data = next_word();
      idx  = data[9:5];
      src  = (op == OP_RWI || op == OP_RSI || op == OP_RCI) ? {27'd0, idx} : data;
      rows.push_back(csr_row(op, A_MSCRATCH, idx, data, scratch));
      case (op)
        OP_RW, OP_RWI: scratch = src;
        OP_RS, OP_RSI: scratch = scratch | src;
        default:       scratch = scratch & ~src;
      endcase
    end
    rows.push_back(read_row(A_MSCRATCH, scratch));
    // ecall into a direct mode vector
    base = next_word() & 32'hFFFF_FFFC;
    p1   = next_word() & 32'hFFFF_FFFC;
    rows.push_back(csr_row(OP_RW, A_MTVEC, 5'd1, base, 32'd0));
    t = idle_row();
    t.ecall = 1'b1;
    t.pc    = p1;
    t = expect_trap(t, 1'b1, base);
    t.chk_raddr = 1'b1;
    t.exp_raddr = p1;
    rows.push_back(t);
    rows.push_back(expect_trap(read_row(A_MCAUSE, 32'd11), 1'b0, 32'd0));
    rows.push_back(read_row(A_MEPC, p1));
    rows.push_back(read_row(A_MSTATUS, MPP_M));
    // misaligned word load followed by the aligned one
    p2    = next_word() & 32'hFFFF_FFFC;
    maddr = next_word() | 32'd2;
    t = idle_row();
    t.is_load  = 1'b1;
    t.mem_size = 2'b10;
    t.mem_addr = maddr;
    t.pc       = p2;
    t = expect_trap(t, 1'b1, base);
    t.chk_raddr = 1'b1;
    t.exp_raddr = p2;
    rows.push_back(t);
    rows.push_back(read_row(A_MCAUSE, 32'd4));
    rows.push_back(read_row(A_MTVAL, maddr));
    t.mem_addr = maddr & 32'hFFFF_FFFC;
    rows.push_back(expect_trap(t, 1'b0, 32'd0));
    // timer interrupt through a vectored table
    vbase = next_word() & 32'hFFFF_FFFC;
    p3    = next_word() & 32'hFFFF_FFFC;
    rows.push_back(csr_row(OP_RW, A_MIE, 5'd2, 32'h0000_0080, 32'd0));
    rows.push_back(csr_row(OP_RW, A_MTVEC, 5'd3, vbase | 32'd1, base));
    rows.push_back(csr_row(OP_RSI, A_MSTATUS, 5'd8, 32'd0, MPP_M));  // uimm 8 is mie
    t = idle_row();
    t.irq_tmr = 1'b1;
    rows.push_back(expect_trap(t, 1'b0, 32'd0));  // only sampled into mip here
    t.pc = p3;
    t = expect_trap(t, 1'b1, vbase + 32'd28);
    t.chk_raddr = 1'b1;
    t.exp_raddr = p3;
    rows.push_back(t);
    rows.push_back(expect_trap(read_row(A_MCAUSE, 32'h8000_0007), 1'b0, 32'd0));
    rows.push_back(read_row(A_MSTATUS, MPP_M | 32'h80));  // mie 0, mpie 1
    // mret back to the interrupted pc
    t = expect_trap(idle_row(), 1'b0, 32'd0);
    t.mret      = 1'b1;
    t.exp_ret   = 1'b1;
    t.chk_raddr = 1'b1;
    t.exp_raddr = p3;
    rows.push_back(t);
    // mret and ecall without valid must neither return nor trap
    t = '0;
    t.mret  = 1'b1;
    t.ecall = 1'b1;
    rows.push_back(expect_trap(t, 1'b0, 32'd0));
    rows.push_back(read_row(A_MSTATUS, MPP_M | 32'h88));
    // flushed write and ecall
    t = expect_trap(csr_row(OP_RW, A_MSCRATCH, 5'd4, next_word(), scratch), 1'b0, 32'd0);
    t.flush = 1'b1;
    rows.push_back(t);
    t = idle_row();
    t.flush = 1'b1;
    t.ecall = 1'b1;
    rows.push_back(expect_trap(t, 1'b0, 32'd0));
    rows.push_back(read_row(A_MSCRATCH, scratch));
    // stall freezes csr_out and every register
    w = next_word();
    rows.push_back(csr_row(OP_RW, A_MSCRATCH, 5'd5, w, scratch));
    for (int k = 0; k < 3; k++) begin
      t = csr_row(OP_RW, A_MSCRATCH, 5'd6, next_word(), scratch);
      t.stall = 1'b1;
      t.ecall = (k == 1);
      rows.push_back(expect_trap(t, 1'b0, 32'd0));
    end
    rows.push_back(read_row(A_MSCRATCH, w));
    rows.push_back(read_row(A_MSTATUS, MPP_M | 32'h88));
    t = read_row(A_MEPC, p3);
    t.chk_raddr = 1'b1;
    t.exp_raddr = p3;
    rows.push_back(t);
  endtask

  task automatic apply_row(input row_t t);
    valid         = t.valid;
    stall         = t.stall;
    flush         = t.flush;
    irq_software  = t.irq_sw;
    irq_timer     = t.irq_tmr;
    irq_external  = t.irq_ext;
    illegal_instr = t.illegal;
    ecall         = t.ecall;
    ebreak        = t.ebreak;
    mret          = t.mret;
    is_load       = t.is_load;
    is_store      = t.is_store;
    mem_size      = t.mem_size;
    mem_addr      = t.mem_addr;
    csr_op        = t.op;
    csr_addr      = t.addr;
    rs1           = t.rs1;
    rs1_data      = t.rs1_data;
    pc            = t.pc;
  endtask

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_row(input row_t t, input int n);
    if (t.chk_out) check_val(csr_out, t.exp_out, $sformatf("row %0d csr_out", n));
    if (t.chk_taken)
      check_val({31'd0, trap_taken}, {31'd0, t.exp_taken}, $sformatf("row %0d trap_taken", n));
    if (t.chk_ret)
      check_val({31'd0, trap_return}, {31'd0, t.exp_ret}, $sformatf("row %0d trap_return", n));
    if (t.chk_taddr) check_val(trap_addr, t.exp_taddr, $sformatf("row %0d trap_addr", n));
    if (t.chk_raddr) check_val(return_addr, t.exp_raddr, $sformatf("row %0d return_addr", n));
  endtask

  initial begin
    rst = 1'b0;
    apply_row('0);
    rng = 32'h5072_dbe1;
    build_table();
    cycle_limit = rows.size() * 2 + RESET_CYCLES + 20;
    repeat (RESET_CYCLES) @(posedge clk);
    #2 rst = 1'b1;
    check_val(csr_out, 32'd0, "csr_out after reset");
    check_val({31'd0, trap_taken}, 32'd0, "trap_taken after reset");
    check_val({31'd0, trap_return}, 32'd0, "trap_return after reset");
    for (int i = 0; i < rows.size(); i++) begin
      @(posedge clk);
      #2;
      if (i > 0) check_row(rows[i-1], i - 1);  // results of the previous edge
      apply_row(rows[i]);
    end
    @(posedge clk);
    #2;
    check_row(rows[rows.size()-1], rows.size() - 1);
    apply_row('0);
    errors = errors + UUT.u_assert.fail_count;
    $display("summary: %0d checks, %0d errors, %0d assertion failures",
             checks, errors, UUT.u_assert.fail_count);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* csr_unit.f */
+incdir+verilog
verilog/csr_pkg.sv
verilog/csr_ifs.sv
verilog/csr_access.sv
verilog/csr_regfile.sv
verilog/trap_ctrl.sv
verilog/csr_unit.sv
bench/csr_unit_assert.sv
bench/csr_unit_tb.sv

/* verilog/csr_access.sv */
// csr instruction decode: picks the source operand and forms the new csr value and write strobe
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_access (
  input  logic               valid,
  input  logic               flush,
  input  csr_pkg::csr_op_t   op,
  input  csr_pkg::csr_addr_t addr,
  input  logic [4:0]         rs1,       // register index, doubles as uimm
  input  csr_pkg::xlen_t     rs1_data,
  csr_access_if.access       bus
);
  import csr_pkg::*;

  xlen_t src;    // operand after register/immediate select
  xlen_t nxt;    // value to be written back
  logic  op_ok;  // funct3 is one of the six csr ops

  // immediate forms carry funct3[2] set, uimm is zero extended
  assign src = op[2] ? {27'b0, rs1} : rs1_data;

  always_comb begin
    op_ok = 1'b1;
    nxt   = bus.rdata;
    case (op)
      `OP_CSRRW,
      `OP_CSRRWI: nxt = src;                 // replace
      `OP_CSRRS,
      `OP_CSRRSI: nxt = bus.rdata | src;     // set bits
      `OP_CSRRC,
      `OP_CSRRCI: nxt = bus.rdata & ~src;    // clear bits
      default: begin
        op_ok = 1'b0;  // 000 and 100 are not csr ops
      end
    endcase
  end

  // a flushed instruction must not touch any csr
  assign bus.wr_en = valid && !flush && op_ok;
  assign bus.addr  = addr;
  assign bus.wdata = nxt;

endmodule

/* verilog/csr_ifs.sv */
// internal buses of the csr unit: the csr access path and the trap control path
`timescale 1ns/1ps

// csr read/modify/write between the decoder and the register file
interface csr_access_if;
  import csr_pkg::*;

  logic      wr_en;  // one-cycle write strobe
  csr_addr_t addr;   // csr index of the current instruction
  xlen_t     wdata;  // value to store
  xlen_t     rdata;  // current value at addr, combinational

  modport access (
    output wr_en,
    output addr,
    output wdata,
    input  rdata
  );

  modport regs (
    input  wr_en,
    input  addr,
    input  wdata,
    output rdata
  );
endinterface

// trap entry/return requests one way, enable and pending state the other
interface csr_trap_if;
  import csr_pkg::*;

  logic        take;       // trap entered on this edge
  logic        ret;        // mret takes effect on this edge
  logic        cause_irq;  // mcause interrupt bit
  cause_code_t cause;
  logic        tval_wr;    // misaligned access, store tval
  xlen_t       tval;
  logic        mstatus_mie;
  logic        mie_msie;
  logic        mie_mtie;
  logic        mie_meie;
  logic        mip_msip;
  logic        mip_mtip;
  logic        mip_meip;
  xlen_t       mtvec;

  modport ctrl (
    output take, ret, cause_irq, cause, tval_wr, tval,
    input  mstatus_mie, mie_msie, mie_mtie, mie_meie,
    input  mip_msip, mip_mtip, mip_meip, mtvec
  );

  modport regs (
    input  take, ret, cause_irq, cause, tval_wr, tval,
    output mstatus_mie, mie_msie, mie_mtie, mie_meie,
    output mip_msip, mip_mtip, mip_meip, mtvec
  );
endinterface

/* verilog/csr_macros.svh */
// shared constants for the csr unit, included by every block that decodes csr fields
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

// machine trap setup addresses
`define CSR_MSTATUS  12'h300
`define CSR_MISA     12'h301
`define CSR_MIE      12'h304
`define CSR_MTVEC    12'h305
// machine trap handling addresses
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC     12'h341
`define CSR_MCAUSE   12'h342
`define CSR_MTVAL    12'h343
`define CSR_MIP      12'h344

// funct3 of the system opcode, bit 2 selects the immediate form
`define OP_CSRRW  3'b001
`define OP_CSRRS  3'b010
`define OP_CSRRC  3'b011
`define OP_CSRRWI 3'b101
`define OP_CSRRSI 3'b110
`define OP_CSRRCI 3'b111

// mcause codes, interrupts then exceptions
`define CAUSE_SW_IRQ         4'd3
`define CAUSE_TIMER_IRQ      4'd7
`define CAUSE_EXT_IRQ        4'd11
`define CAUSE_ILLEGAL        4'd2
`define CAUSE_BREAK          4'd3
`define CAUSE_LOAD_MISALIGN  4'd4
`define CAUSE_STORE_MISALIGN 4'd6
`define CAUSE_ECALL          4'd11

// bit positions inside mstatus, mie and mip
`define BIT_MIE  3
`define BIT_MPIE 7
`define BIT_MPP  11  // low bit of the two-bit mpp field
`define BIT_SIE  3
`define BIT_TIE  7
`define BIT_EIE  11

`define CSR_RESET_MTVEC 32'h0000_0000  // direct mode, base 0
`define CSR_MISA_VALUE  32'h4000_0100  // mxl=1 (rv32), extension i only

`endif

/* verilog/csr_pkg.sv */
// type definitions shared by the csr unit blocks, imported by each module and interface

package csr_pkg;

  // architectural data word
  typedef logic [31:0] xlen_t;

  // csr index carried in the immediate field
  typedef logic [11:0] csr_addr_t;

  // funct3 of a csr instruction
  typedef logic [2:0] csr_op_t;

  // exception code part of mcause
  typedef logic [3:0] cause_code_t;

  // load/store width, low two bits of funct3
  //   00 byte, 01 halfword, 10 word
  typedef logic [1:0] mem_size_t;

endpackage

/* verilog/csr_regfile.sv */
// machine-mode csr storage with read mux, software writes and trap entry/return updates
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_regfile (
  input  logic           clk,
  input  logic           rst,
  input  logic           stall,
  input  csr_pkg::xlen_t pc,
  input  logic           irq_software,
  input  logic           irq_timer,
  input  logic           irq_external,
  output csr_pkg::xlen_t return_addr,
  csr_access_if.regs     bus,
  csr_trap_if.regs       trap
);
  import csr_pkg::*;

  // mstatus, only the interrupt enable pair is writable
  logic        mstatus_mie;
  logic        mstatus_mpie;
  // mie enables
  logic        mie_msie;
  logic        mie_mtie;
  logic        mie_meie;
  xlen_t       mtvec;      // base in [31:2], mode in [1:0]
  xlen_t       mscratch;
  xlen_t       mepc;
  logic        mcause_irq;
  cause_code_t mcause_code;
  xlen_t       mtval;
  // mip, sampled from the pins
  logic        mip_msip;
  logic        mip_mtip;
  logic        mip_meip;

  // per-register write strobes
  logic wr_mstatus;
  logic wr_mie;
  logic wr_mtvec;
  logic wr_mscratch;
  logic wr_mepc;
  logic wr_mcause;
  logic wr_mtval;

  assign wr_mstatus  = bus.wr_en && (bus.addr == `CSR_MSTATUS);
  assign wr_mie      = bus.wr_en && (bus.addr == `CSR_MIE);
  assign wr_mtvec    = bus.wr_en && (bus.addr == `CSR_MTVEC);
  assign wr_mscratch = bus.wr_en && (bus.addr == `CSR_MSCRATCH);
  assign wr_mepc     = bus.wr_en && (bus.addr == `CSR_MEPC);
  assign wr_mcause   = bus.wr_en && (bus.addr == `CSR_MCAUSE);
  assign wr_mtval    = bus.wr_en && (bus.addr == `CSR_MTVAL);

  // read mux, unmapped addresses read zero
  always_comb begin
    bus.rdata = '0;
    case (bus.addr)
      `CSR_MSTATUS: begin
        bus.rdata[`BIT_MIE]              = mstatus_mie;
        bus.rdata[`BIT_MPIE]             = mstatus_mpie;
        bus.rdata[`BIT_MPP+1:`BIT_MPP]   = 2'b11;  // mpp tied to machine
      end
      `CSR_MISA: bus.rdata = `CSR_MISA_VALUE;
      `CSR_MIE: begin
        bus.rdata[`BIT_SIE] = mie_msie;
        bus.rdata[`BIT_TIE] = mie_mtie;
        bus.rdata[`BIT_EIE] = mie_meie;
      end
      `CSR_MTVEC:    bus.rdata = mtvec;
      `CSR_MSCRATCH: bus.rdata = mscratch;
      `CSR_MEPC:     bus.rdata = mepc;
      `CSR_MCAUSE: begin
        bus.rdata[31]  = mcause_irq;
        bus.rdata[3:0] = mcause_code;
      end
      `CSR_MTVAL: bus.rdata = mtval;
      `CSR_MIP: begin
        bus.rdata[`BIT_SIE] = mip_msip;
        bus.rdata[`BIT_TIE] = mip_mtip;
        bus.rdata[`BIT_EIE] = mip_meip;
      end
      default: bus.rdata = '0;
    endcase
  end

  // mstatus: trap entry, then mret, then software
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      mstatus_mie  <= 1'b0;
      mstatus_mpie <= 1'b0;
    end else if (!stall) begin
      if (trap.take) begin
        mstatus_mpie <= mstatus_mie;
        mstatus_mie  <= 1'b0;  // no nesting inside the handler
      end else if (trap.ret) begin
        mstatus_mie  <= mstatus_mpie;
        mstatus_mpie <= 1'b1;
      end else if (wr_mstatus) begin
        mstatus_mie  <= bus.wdata[`BIT_MIE];
        mstatus_mpie <= bus.wdata[`BIT_MPIE];
      end
    end
  end

  // software-only registers and the pending samples
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      mie_msie <= 1'b0;
      mie_mtie <= 1'b0;
      mie_meie <= 1'b0;
      mtvec    <= `CSR_RESET_MTVEC;
      mscratch <= '0;
      mip_msip <= 1'b0;
      mip_mtip <= 1'b0;
      mip_meip <= 1'b0;
    end else if (!stall) begin
      if (wr_mie) begin
        mie_msie <= bus.wdata[`BIT_SIE];
        mie_mtie <= bus.wdata[`BIT_TIE];
        mie_meie <= bus.wdata[`BIT_EIE];
      end
      if (wr_mtvec) mtvec <= bus.wdata;
      if (wr_mscratch) mscratch <= bus.wdata;
      mip_msip <= irq_software;  // one edge of latency to pending
      mip_mtip <= irq_timer;
      mip_meip <= irq_external;
    end
  end

  // trap handling registers, the trap update wins over a write
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      mepc        <= '0;
      mcause_irq  <= 1'b0;
      mcause_code <= '0;
      mtval       <= '0;
    end else if (!stall) begin
      if (trap.take) begin
        mepc        <= pc;
        mcause_irq  <= trap.cause_irq;
        mcause_code <= trap.cause;
      end else begin
        if (wr_mepc) mepc <= {bus.wdata[31:2], 2'b00};  // word aligned only
        if (wr_mcause) begin
          mcause_irq  <= bus.wdata[31];
          mcause_code <= bus.wdata[3:0];
        end
      end
      if (trap.take && trap.tval_wr) mtval <= trap.tval;  // faulting address
      else if (wr_mtval) mtval <= bus.wdata;
    end
  end

  assign return_addr      = mepc;
  assign trap.mstatus_mie = mstatus_mie;
  assign trap.mie_msie    = mie_msie;
  assign trap.mie_mtie    = mie_mtie;
  assign trap.mie_meie    = mie_meie;
  assign trap.mip_msip    = mip_msip;
  assign trap.mip_mtip    = mip_mtip;
  assign trap.mip_meip    = mip_meip;
  assign trap.mtvec       = mtvec;

endmodule

/* verilog/csr_unit.sv */
// top level of the machine-mode csr unit, connects decode, storage and trap control to the pins
`timescale 1ns/1ps

module csr_unit (
  input  logic               clk,
  input  logic               rst,
  input  logic               valid,
  input  logic               stall,
  input  logic               flush,
  input  logic               irq_software,
  input  logic               irq_timer,
  input  logic               irq_external,
  input  logic               illegal_instr,
  input  logic               ecall,
  input  logic               ebreak,
  input  logic               mret,
  input  logic               is_load,
  input  logic               is_store,
  input  csr_pkg::mem_size_t mem_size,
  input  csr_pkg::xlen_t     mem_addr,
  input  csr_pkg::csr_op_t   csr_op,
  input  csr_pkg::csr_addr_t csr_addr,
  input  logic [4:0]         rs1,
  input  csr_pkg::xlen_t     rs1_data,
  input  csr_pkg::xlen_t     pc,
  output csr_pkg::xlen_t     csr_out,
  output logic               trap_taken,
  output logic               trap_return,
  output csr_pkg::xlen_t     trap_addr,
  output csr_pkg::xlen_t     return_addr
);

  csr_access_if acc_if ();
  csr_trap_if   trp_if ();

  csr_access u_access (
    .valid    (valid),
    .flush    (flush),
    .op       (csr_op),
    .addr     (csr_addr),
    .rs1      (rs1),
    .rs1_data (rs1_data),
    .bus      (acc_if.access)
  );

  csr_regfile u_regfile (
    .clk          (clk),
    .rst          (rst),
    .stall        (stall),
    .pc           (pc),
    .irq_software (irq_software),
    .irq_timer    (irq_timer),
    .irq_external (irq_external),
    .return_addr  (return_addr),
    .bus          (acc_if.regs),
    .trap         (trp_if.regs)
  );

  trap_ctrl u_trap (
    .clk           (clk),
    .rst           (rst),
    .valid         (valid),
    .stall         (stall),
    .flush         (flush),
    .illegal_instr (illegal_instr),
    .ecall         (ecall),
    .ebreak        (ebreak),
    .mret          (mret),
    .is_load       (is_load),
    .is_store      (is_store),
    .mem_size      (mem_size),
    .mem_addr      (mem_addr),
    .trap_taken    (trap_taken),
    .trap_return   (trap_return),
    .trap_addr     (trap_addr),
    .trap          (trp_if.ctrl)
  );

  // old csr value, captured on the same edge as the write
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) csr_out <= '0;
    else if (valid && !stall) csr_out <= acc_if.rdata;
  end

endmodule

/* verilog/trap_ctrl.sv */
// trap detection: misaligned accesses, pending interrupts, cause priority and registered trap outputs
`timescale 1ns/1ps
`include "csr_macros.svh"

module trap_ctrl (
  input  logic               clk,
  input  logic               rst,
  input  logic               valid,
  input  logic               stall,
  input  logic               flush,
  input  logic               illegal_instr,
  input  logic               ecall,
  input  logic               ebreak,
  input  logic               mret,
  input  logic               is_load,
  input  logic               is_store,
  input  csr_pkg::mem_size_t mem_size,
  input  csr_pkg::xlen_t     mem_addr,
  output logic               trap_taken,
  output logic               trap_return,
  output csr_pkg::xlen_t     trap_addr,
  csr_trap_if.ctrl           trap
);
  import csr_pkg::*;

  logic  misalign;   // address breaks natural alignment
  logic  load_mis;
  logic  store_mis;
  logic  ext_pend;
  logic  sw_pend;
  logic  tmr_pend;
  logic  irq_any;
  logic  exc_any;
  xlen_t base;
  xlen_t vec_addr;

  always_comb begin
    case (mem_size)
      2'b01:   misalign = mem_addr[0];     // halfword
      2'b10:   misalign = |mem_addr[1:0];  // word
      default: misalign = 1'b0;            // bytes never fault
    endcase
  end

  assign load_mis  = is_load && misalign;
  assign store_mis = is_store && misalign;

  // pending = global enable & local enable & pending bit
  assign ext_pend = trap.mstatus_mie && trap.mie_meie && trap.mip_meip;
  assign sw_pend  = trap.mstatus_mie && trap.mie_msie && trap.mip_msip;
  assign tmr_pend = trap.mstatus_mie && trap.mie_mtie && trap.mip_mtip;
  assign irq_any  = ext_pend || sw_pend || tmr_pend;

  // flush kills exceptions but not interrupts
  assign exc_any = !flush && (illegal_instr || ecall || ebreak || load_mis || store_mis);

  // at most one take per trap, the cycle after is always quiet
  assign trap.take = valid && !trap_taken && (irq_any || exc_any);
  assign trap.ret  = valid && mret && !trap.take;
  assign trap.tval = mem_addr;

  // cause priority, interrupts first
  always_comb begin
    trap.cause_irq = 1'b0;
    trap.cause     = '0;
    trap.tval_wr   = 1'b0;
    if (ext_pend) begin
      trap.cause_irq = 1'b1;
      trap.cause     = `CAUSE_EXT_IRQ;
    end else if (sw_pend) begin
      trap.cause_irq = 1'b1;
      trap.cause     = `CAUSE_SW_IRQ;
    end else if (tmr_pend) begin
      trap.cause_irq = 1'b1;
      trap.cause     = `CAUSE_TIMER_IRQ;
    end else if (illegal_instr) begin
      trap.cause = `CAUSE_ILLEGAL;
    end else if (ecall) begin
      trap.cause = `CAUSE_ECALL;
    end else if (ebreak) begin
      trap.cause = `CAUSE_BREAK;
    end else if (load_mis) begin
      trap.cause   = `CAUSE_LOAD_MISALIGN;
      trap.tval_wr = 1'b1;
    end else if (store_mis) begin
      trap.cause   = `CAUSE_STORE_MISALIGN;
      trap.tval_wr = 1'b1;
    end
  end

  assign base = {trap.mtvec[31:2], 2'b00};
  // vectored mode only offsets interrupts, by 4*cause
  assign vec_addr = (trap.mtvec[1:0] == 2'd1 && trap.cause_irq) ?
                    base + {26'b0, trap.cause, 2'b00} : base;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      trap_taken  <= 1'b0;
      trap_return <= 1'b0;
    end else if (!stall) begin
      trap_taken  <= trap.take;  // low on any invalid edge
      trap_return <= trap.ret;
    end
  end

  // target held until the next trap
  always_ff @(posedge clk) begin
    if (!stall && trap.take) trap_addr <= vec_addr;
  end

endmodule
